// File: src/wave_pkg.sv
`default_nettype none

package wave_pkg;

    ////////////////////////////////////////
    // video timing, 640x480 at 25 mhz
    ////////////////////////////////////////

    // horizontal, in pixel clocks
    localparam logic [11:0] H_SYNC  = 12'd96;   // sync pulse
    localparam logic [11:0] H_BACK  = 12'd40;   // back porch
    localparam logic [11:0] H_LEFT  = 12'd8;    // left border
    localparam logic [11:0] H_VALID = 12'd640;  // visible columns
    localparam logic [11:0] H_RIGHT = 12'd8;    // right border
    localparam logic [11:0] H_FRONT = 12'd8;    // front porch
    localparam logic [11:0] H_TOTAL = H_SYNC + H_BACK + H_LEFT + H_VALID
                                    + H_RIGHT + H_FRONT;  // 800

    // vertical, in lines
    localparam logic [11:0] V_SYNC   = 12'd2;
    localparam logic [11:0] V_BACK   = 12'd25;
    localparam logic [11:0] V_TOP    = 12'd8;
    localparam logic [11:0] V_VALID  = 12'd480;
    localparam logic [11:0] V_BOTTOM = 12'd8;
    localparam logic [11:0] V_FRONT  = 12'd2;
    localparam logic [11:0] V_TOTAL  = V_SYNC + V_BACK + V_TOP + V_VALID
                                     + V_BOTTOM + V_FRONT;  // 525

    // first visible column / line
    localparam logic [11:0] H_ACT_START = H_SYNC + H_BACK + H_LEFT;  // 144
    localparam logic [11:0] V_ACT_START = V_SYNC + V_BACK + V_TOP;   // 35

    ////////////////////////////////////////
    // sample and pixel types
    ////////////////////////////////////////

    typedef logic [7:0] wave_sample_t;  // unsigned sample byte
    typedef logic [8:0] wave_addr_t;    // index into one bank

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // pixel whose colour is due next cycle
    typedef struct packed {
        logic        req;
        logic [11:0] x;
        logic [11:0] y;
    } pix_pos_t;

    typedef struct packed {
        logic       en;
        wave_addr_t addr;
    } wave_rd_t;

    ////////////////////////////////////////
    // trace, grid and colours
    ////////////////////////////////////////

    localparam wave_addr_t  WAVE_LEN  = 9'd300;   // samples per trace
    localparam logic [11:0] TRACE_TOP = 12'd112;  // top row of 256-row band
    localparam logic [5:0]  GRID_X    = 6'd50;    // column pitch
    localparam logic [5:0]  GRID_Y    = 6'd60;    // row pitch

    localparam rgb565_t COLOR_TRACE = 16'hffe0;  // yellow
    localparam rgb565_t COLOR_GRID  = 16'h4208;  // dark grey
    localparam rgb565_t COLOR_BG    = 16'h0000;  // black

endpackage

`default_nettype wire

// File: src/vga_ctrl.sv
`default_nettype none

module vga_ctrl import wave_pkg::*; (
    input  wire     vga_clk,
    input  wire     sys_rst_n,
    input  rgb565_t pix_data,   // colour from painter, one cycle after req

    output pix_pos_t pix_pos,   // position needed next cycle
    output wave_rd_t wave_rd,   // sample fetch, two cycles ahead
    output logic     frame_end, // last pixel of last line
    output logic     hsync,
    output logic     vsync,
    output logic     rgb_valid,
    output rgb565_t  rgb
);

    logic [11:0] cnt_h;  // pixel within line
    logic [11:0] cnt_v;  // line within frame
    logic        line_end;
    logic        line_act;  // visible line
    logic        req_win;   // one cycle before visible column
    logic        rd_win;    // two cycles before, first WAVE_LEN columns only

    ////////////////////////////////////////
    // line and frame counters
    ////////////////////////////////////////

    assign line_end = (cnt_h == H_TOTAL - 12'd1);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_h <= '0;
        end else if (line_end) begin
            cnt_h <= '0;
        end else begin
            cnt_h <= cnt_h + 12'd1;
        end
    end

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_v <= '0;
        end else if (line_end) begin
            if (cnt_v == V_TOTAL - 12'd1) begin
                cnt_v <= '0;  // wrap frame
            end else begin
                cnt_v <= cnt_v + 12'd1;
            end
        end
    end

    ////////////////////////////////////////
    // sync and windows
    ////////////////////////////////////////

    assign hsync     = (cnt_h < H_SYNC);  // active high, as on the board
    assign vsync     = (cnt_v < V_SYNC);
    assign frame_end = line_end && (cnt_v == V_TOTAL - 12'd1);

    assign line_act = (cnt_v >= V_ACT_START) && (cnt_v < V_ACT_START + V_VALID);

    assign rgb_valid = line_act
                     && (cnt_h >= H_ACT_START)
                     && (cnt_h < H_ACT_START + H_VALID);

    // colour request leads the beam by one
    assign req_win = line_act
                   && (cnt_h >= H_ACT_START - 12'd1)
                   && (cnt_h < H_ACT_START + H_VALID - 12'd1);

    // ram fetch leads by two, covers trace columns
    assign rd_win = line_act
                  && (cnt_h >= H_ACT_START - 12'd2)
                  && (cnt_h < H_ACT_START - 12'd2 + {3'd0, WAVE_LEN});

    ////////////////////////////////////////
    // position, fetch, pixel out
    ////////////////////////////////////////

    always_comb begin
        pix_pos.req = req_win;
        pix_pos.x   = req_win ? (cnt_h - (H_ACT_START - 12'd1)) : '1;  // all ones idle
        pix_pos.y   = req_win ? (cnt_v - V_ACT_START) : '1;
    end

    always_comb begin
        wave_rd.en   = rd_win;
        wave_rd.addr = rd_win ? wave_addr_t'(cnt_h - (H_ACT_START - 12'd2)) : '0;
    end

    assign rgb = rgb_valid ? pix_data : '0;  // black in blanking

endmodule

`default_nettype wire

// File: src/wave_capture.sv
`default_nettype none

module wave_capture import wave_pkg::*; (
    input  wire          vga_clk,
    input  wire          sys_rst_n,
    input  wave_sample_t sample,
    input  wire          sample_valid,  // single-cycle strobe
    input  wire          frame_end,

    output logic         wr_en,
    output logic         wr_bank,
    output wave_addr_t   wr_addr,
    output wave_sample_t wr_data,
    output logic         disp_bank      // bank the display reads
);

    wave_addr_t fill_cnt;  // samples stored in fill bank
    logic       full;      // fill bank holds WAVE_LEN samples
    logic       accept;
    logic       last;      // this strobe completes the buffer

    assign accept = sample_valid && !full;  // extra strobes dropped
    assign last   = (fill_cnt == WAVE_LEN - 9'd1);

    ////////////////////////////////////////
    // fill count, full flag, bank swap
    ////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            fill_cnt  <= '0;
            full      <= 1'b0;
            disp_bank <= 1'b0;  // fill side starts at bank 1
        end else if (frame_end && full) begin
            // new buffer goes on screen for the coming frame
            disp_bank <= ~disp_bank;
            fill_cnt  <= '0;
            full      <= 1'b0;
        end else if (accept) begin
            fill_cnt <= fill_cnt + 9'd1;
            full     <= last;
        end
    end

    ////////////////////////////////////////
    // write port, one cycle after strobe
    ////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept;
        end
    end

    // payload follows the enable
    always_ff @(posedge vga_clk) begin
        if (accept) begin
            wr_bank <= ~disp_bank;  // always the hidden bank
            wr_addr <= fill_cnt;
            wr_data <= sample;
        end
    end

endmodule

`default_nettype wire

// File: src/wave_ram.sv
`default_nettype none

module wave_ram import wave_pkg::*; (
    input  wire          vga_clk,
    input  wire          wr_en,
    input  wire          wr_bank,
    input  wave_addr_t   wr_addr,
    input  wave_sample_t wr_data,
    input  wire          rd_bank,
    input  wave_rd_t     rd,

    output wave_sample_t rd_data  // valid one cycle after rd.en
);

    // two banks, block ram
    wave_sample_t mem [2][WAVE_LEN];

    ////////////////////////////////////////
    // write side, from capture
    ////////////////////////////////////////

    always_ff @(posedge vga_clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // read side, from timing
    ////////////////////////////////////////

    always_ff @(posedge vga_clk) begin
        if (rd.en) begin
            rd_data <= mem[rd_bank][rd.addr];  // holds between fetches
        end
    end

endmodule

`default_nettype wire

// File: src/wave_painter.sv
`default_nettype none

module wave_painter import wave_pkg::*; (
    input  wire          vga_clk,
    input  wire          sys_rst_n,
    input  pix_pos_t     pix_pos,  // pixel due next cycle
    input  wave_sample_t rd_data,  // sample for pix_pos.x, same cycle

    output rgb565_t      pix_data
);

    logic [5:0]  col_ph;     // x mod GRID_X for next req pixel
    logic [5:0]  row_ph;     // y mod GRID_Y for next line
    logic [5:0]  col_cur;
    logic [5:0]  row_cur;
    logic        col_hit;
    logic        row_hit;
    logic [11:0] trace_row;  // screen row of the sample
    logic        trace_hit;
    logic        line_last;  // last visible column

    ////////////////////////////////////////
    // grid phase, no dividers
    ////////////////////////////////////////

    // restart at the left edge and the top line
    assign col_cur   = (pix_pos.x == 12'd0) ? 6'd0 : col_ph;
    assign row_cur   = (pix_pos.y == 12'd0) ? 6'd0 : row_ph;
    assign line_last = (pix_pos.x == H_VALID - 12'd1);

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            col_ph <= '0;
            row_ph <= '0;
        end else if (pix_pos.req) begin
            // column step every pixel
            col_ph <= (col_cur == GRID_X - 6'd1) ? 6'd0 : col_cur + 6'd1;
            if (line_last) begin  // row step once per line
                row_ph <= (row_cur == GRID_Y - 6'd1) ? 6'd0 : row_cur + 6'd1;
            end
        end
    end

    assign col_hit = (col_cur == 6'd0);
    assign row_hit = (row_cur == 6'd0);

    ////////////////////////////////////////
    // trace compare
    ////////////////////////////////////////

    // sample 255 at top of band, 0 at bottom
    assign trace_row = TRACE_TOP + 12'd255 - {4'd0, rd_data};
    assign trace_hit = (pix_pos.x < {3'd0, WAVE_LEN}) && (pix_pos.y == trace_row);

    ////////////////////////////////////////
    // colour register
    ////////////////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pix_data <= COLOR_BG;
        end else if (!pix_pos.req) begin
            pix_data <= COLOR_BG;  // blanking
        end else if (trace_hit) begin
            pix_data <= COLOR_TRACE;  // trace wins over grid
        end else if (col_hit || row_hit) begin
            pix_data <= COLOR_GRID;
        end else begin
            pix_data <= COLOR_BG;
        end
    end

endmodule

`default_nettype wire

// File: src/wave_display_top.sv
`default_nettype none

module wave_display_top import wave_pkg::*; (
    input  wire          vga_clk,
    input  wire          sys_rst_n,
    input  wave_sample_t sample,
    input  wire          sample_valid,

    output logic         hsync,
    output logic         vsync,
    output logic         rgb_valid,
    output rgb565_t      rgb
);

    // timing side
    pix_pos_t     pix_pos;
    wave_rd_t     wave_rd;
    rgb565_t      pix_data;
    logic         frame_end;

    // capture side
    logic         wr_en;
    logic         wr_bank;
    wave_addr_t   wr_addr;
    wave_sample_t wr_data;
    logic         disp_bank;
    wave_sample_t rd_data;

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////

    vga_ctrl vga_ctrl_inst (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_data  (pix_data),
        .pix_pos   (pix_pos),
        .wave_rd   (wave_rd),
        .frame_end (frame_end),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb_valid (rgb_valid),
        .rgb       (rgb)
    );

    wave_capture wave_capture_inst (
        .vga_clk      (vga_clk),
        .sys_rst_n    (sys_rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .frame_end    (frame_end),  // swap point
        .wr_en        (wr_en),
        .wr_bank      (wr_bank),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .disp_bank    (disp_bank)
    );

    wave_ram wave_ram_inst (
        .vga_clk (vga_clk),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_bank (disp_bank),
        .rd      (wave_rd),
        .rd_data (rd_data)
    );

    wave_painter wave_painter_inst (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_pos   (pix_pos),
        .rd_data   (rd_data),
        .pix_data  (pix_data)
    );

endmodule

`default_nettype wire

// File: verification/wave_display_checks.svh
`ifndef WAVE_DISPLAY_CHECKS_SVH
`define WAVE_DISPLAY_CHECKS_SVH

////////////////////////////////////////
// reference colour rule
////////////////////////////////////////

// trace first, then grid, then black
function automatic rgb565_t expected_colour(input int x, input int y, input wave_sample_t s);
    int trace_y;
    trace_y = int'(TRACE_TOP) + 255 - int'(s);  // 255 at top of band
    if ((x < int'(WAVE_LEN)) && (y == trace_y)) begin
        return COLOR_TRACE;
    end else if ((x % int'(GRID_X) == 0) || (y % int'(GRID_Y) == 0)) begin
        return COLOR_GRID;
    end else begin
        return COLOR_BG;
    end
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_rgb(input string what, input int x, input int y,
                         input rgb565_t expected, input rgb565_t seen);
    if (seen !== expected) begin
        $display("[ERROR] %0t ns: %s at x=%0d y=%0d, expected %h seen %h",
                 $time, what, x, y, expected, seen);
        stop_on_failure("wrong pixel value");
    end
endtask

task automatic check_sync(input string what, input int expected, input int seen);
    if (seen != expected) begin
        $display("[ERROR] %0t ns: %s, expected %0d seen %0d", $time, what, expected, seen);
        stop_on_failure("wrong sync or window count");
    end
endtask

// one visible pixel against the reference buffer
task automatic check_sample_pixel(input int x, input int y, input int bufnum,
                                  input rgb565_t seen);
    wave_sample_t s;
    rgb565_t      expected;
    if ((x < 0) || (x >= int'(H_VALID)) || (y < 0) || (y >= int'(V_VALID))) begin
        stop_on_failure($sformatf("rgb_valid was high outside the active area at x=%0d y=%0d",
                                  x, y));
    end else begin
        s        = (x < int'(WAVE_LEN)) ? ref_buf[bufnum][x] : '0;  // no sample past trace
        expected = expected_colour(x, y, s);
        check_rgb("pixel colour", x, y, expected, seen);
    end
endtask

`endif

// File: verification/wave_display_tb.sv
`default_nettype none

module wave_display_tb import wave_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int VEC_WORDS     = 160;  // 32 segments of 5 words
    localparam int FRAME_CYCLES  = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES;

    logic         vga_clk;
    logic         sys_rst_n;
    wave_sample_t sample;
    logic         sample_valid;
    logic         hsync;
    logic         vsync;
    logic         rgb_valid;
    rgb565_t      rgb;

    logic [15:0]  vec_mem [VEC_WORDS];       // raw segment words
    wave_sample_t ref_buf [3][WAVE_LEN];     // expanded buffers
    int           buf_len [3];

    wave_display_top wave_display_top_inst (
        .vga_clk      (vga_clk),
        .sys_rst_n    (sys_rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb_valid    (rgb_valid),
        .rgb          (rgb)
    );

    initial begin
        vga_clk = 1'b0;
        forever #50 vga_clk = ~vga_clk;  // 10 mhz sim clock
    end

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    `include "wave_display_checks.svh"

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic load_vectors();
        int          i;
        int          k;
        int          b;
        int          start;
        int          cnt;
        logic [7:0]  val;
        logic [7:0]  step;
        $readmemh("verification/wave_display_vectors.txt", vec_mem);
        for (b = 0; b < 3; b++) buf_len[b] = 0;
        i = 0;
        while ((i + 4 < VEC_WORDS) && !$isunknown(vec_mem[i]) && (vec_mem[i] != 16'hffff)) begin
            b     = vec_mem[i];
            start = vec_mem[i+1];
            cnt   = vec_mem[i+2];
            val   = vec_mem[i+3][7:0];
            step  = vec_mem[i+4][7:0];  // step wraps so ff counts down
            if ((b > 2) || (start + cnt > int'(WAVE_LEN))) begin
                stop_on_failure("vectors file holds a segment outside the buffers");
            end
            for (k = 0; k < cnt; k++) begin
                ref_buf[b][start+k] = val;
                val = val + step;
            end
            if (start + cnt > buf_len[b]) buf_len[b] = start + cnt;
            i += 5;
        end
        if ((buf_len[0] != int'(WAVE_LEN)) || (buf_len[1] != int'(WAVE_LEN))
                || (buf_len[2] == 0) || (buf_len[2] >= int'(WAVE_LEN))) begin
            stop_on_failure("vectors file does not give two full buffers and one partial");
        end
    endtask

    // strobes with 0 to 3 idle cycles between
    task automatic send_buffer(input int bufnum);
        int i;
        int idle;
        for (i = 0; i < buf_len[bufnum]; i++) begin
            @(posedge vga_clk);
            sample       <= ref_buf[bufnum][i];
            sample_valid <= 1'b1;
            idle = $urandom % 4;
            repeat (idle) begin
                @(posedge vga_clk);
                sample_valid <= 1'b0;
            end
        end
        @(posedge vga_clk);
        sample_valid <= 1'b0;
    endtask

    ////////////////////////////////////////
    // frame scanning
    ////////////////////////////////////////

    // returns on the negedge of the first cycle of a frame
    task automatic wait_frame_start();
        logic prev;
        int   n;
        @(negedge vga_clk);
        prev = vsync;
        for (n = 0; n < FRAME_TIMEOUT; n++) begin
            @(negedge vga_clk);
            if (vsync && !prev) return;
            prev = vsync;
        end
        stop_on_failure("timed out waiting for the start of a video frame");
    endtask

    // one whole frame from its first cycle
    task automatic scan_frame(input int bufnum);
        int h;
        int v;
        int hs_seen;
        int act_seen;
        int vs_lines;
        int act_exp;
        vs_lines = 0;
        for (v = 0; v < int'(V_TOTAL); v++) begin
            hs_seen  = 0;
            act_seen = 0;
            if (vsync) vs_lines++;  // sampled at line start
            for (h = 0; h < int'(H_TOTAL); h++) begin
                if (hsync) hs_seen++;
                if (rgb_valid) begin
                    act_seen++;
                    check_sample_pixel(h - int'(H_ACT_START), v - int'(V_ACT_START),
                                       bufnum, rgb);
                end else begin
                    check_rgb("rgb not zero in blanking (raw counters)", h, v, '0, rgb);
                end
                @(negedge vga_clk);
            end
            act_exp = ((v >= int'(V_ACT_START)) && (v < int'(V_ACT_START + V_VALID)))
                    ? int'(H_VALID) : 0;
            check_sync($sformatf("hsync cycles in line %0d", v), int'(H_SYNC), hs_seen);
            check_sync($sformatf("rgb_valid cycles in line %0d", v), act_exp, act_seen);
        end
        check_sync("vsync lines per frame", int'(V_SYNC), vs_lines);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'h0a99_e09b));
        sys_rst_n    = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        load_vectors();
        repeat (8) @(posedge vga_clk);
        sys_rst_n <= 1'b1;

        send_buffer(0);        // fills hidden bank during frame 0
        wait_frame_start();    // swap at frame end
        scan_frame(0);

        send_buffer(1);
        wait_frame_start();
        scan_frame(1);         // swapped bank holds buffer 1 only

        send_buffer(2);        // never completes so no swap
        wait_frame_start();
        scan_frame(1);
        scan_frame(1);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/wave_display_vectors.txt
// ramp segments, all fields hex, one segment per line
// columns: buffer  start_index  count  start_value  step (8 bit, wraps)
// buffer 0, triangle 20 up to 169 and back down
0000 0000 0064 0014 0001
0000 0064 0032 0078 0001
0000 0096 004b 00a9 00ff
0000 00e1 004b 005e 00ff
// buffer 1, falling ramp, rising ramp, flat line
0001 0000 0064 00fa 00ff
0001 0064 0032 0000 0001
0001 0096 0032 0032 0001
0001 00c8 0064 00c8 0000
// buffer 2, partial, wrapping ramp
0002 0000 005a 0050 0003
0002 005a 005a 005e 0003
// end marker
ffff ffff ffff ffff ffff

// File: project.f
+incdir+verification
src/wave_pkg.sv
src/vga_ctrl.sv
src/wave_capture.sv
src/wave_ram.sv
src/wave_painter.sv
src/wave_display_top.sv
verification/wave_display_tb.sv
